/* Makefile */
SIM := obj_dir/Vtb_mips

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "Test passed" sim.log

$(SIM): flist.f $(shell cat flist.f)
	verilator --binary --timing --assert --top-module tb_mips -f flist.f

clean:
	rm -rf obj_dir sim.log

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import mips_pkg::*; (
	input  wire logic      clk,
	input  wire logic      rst,
	fd_if.decode           fd,
	dx_if.decode           dx,
	xm_if.observe          xm,
	hazard_if.decode       hz,
	input  wire logic      wb_en,
	input  wire reg_addr_t wb_addr,
	input  wire word_t     wb_data
);

	opcode_t     opcode;
	logic [5:0]  funct;
	reg_addr_t   rs, rt, rd, dest;
	logic [15:0] imm16;
	word_t       imm_ext;
	word_t       regs [32];
	word_t       rf_rs, rf_rt, cmp_a, cmp_b;
	alu_op_t     alu_op;
	logic        alu_src, reg_dst, reg_write, mem_to_reg, mem_write;
	logic        branch, is_bne, jump, zero_ext, uses_rs, uses_rt, wr_ok, taken;

	assign opcode = opcode_t'(fd.instr[31:26]);
	assign rs     = fd.instr[25:21];
	assign rt     = fd.instr[20:16];
	assign rd     = fd.instr[15:11];
	assign funct  = fd.instr[5:0];
	assign imm16  = fd.instr[15:0];

	// ------------------------------------------------------------
	// Control decode
	// ------------------------------------------------------------
	// Anything unknown falls through as a bubble
	always_comb begin
		alu_op     = ALU_ADD;
		alu_src    = 1'b0;
		reg_dst    = 1'b0;
		reg_write  = 1'b0;
		mem_to_reg = 1'b0;
		mem_write  = 1'b0;
		branch     = 1'b0;
		is_bne     = 1'b0;
		jump       = 1'b0;
		zero_ext   = 1'b0;
		uses_rs    = 1'b0;
		uses_rt    = 1'b0;
		case (opcode)
			OP_RTYPE: begin
				reg_dst   = 1'b1;
				reg_write = 1'b1;
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
				case (funct)
					FUNCT_ADD: alu_op = ALU_ADD;
					FUNCT_SUB: alu_op = ALU_SUB;
					FUNCT_AND: alu_op = ALU_AND;
					FUNCT_OR:  alu_op = ALU_OR;
					FUNCT_SLT: alu_op = ALU_SLT;
					default: begin
						reg_write = 1'b0;
						uses_rs   = 1'b0;
						uses_rt   = 1'b0;
					end
				endcase
			end
			OP_ADDI, OP_ORI, OP_LW: begin
				alu_src    = 1'b1;
				reg_write  = 1'b1;
				uses_rs    = 1'b1;
				mem_to_reg = (opcode == OP_LW);
				zero_ext   = (opcode == OP_ORI);
				alu_op     = (opcode == OP_ORI) ? ALU_OR : ALU_ADD;
			end
			OP_SW: begin
				alu_src   = 1'b1;
				mem_write = 1'b1;
				uses_rs   = 1'b1;
				uses_rt   = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				branch  = 1'b1;
				is_bne  = (opcode == OP_BNE);
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			OP_J:    jump = 1'b1;
			default: jump = 1'b0;
		endcase
	end

	// Writes to r0 are dropped here so nothing downstream sees them
	assign dest    = reg_dst ? rd : rt;
	assign wr_ok   = reg_write && (dest != '0);
	assign imm_ext = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

	// ------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wb_en && wb_addr != '0)
			regs[wb_addr] <= wb_data;
	end

	// Write-first bypass means writeback needs no forward here
	assign rf_rs = (rs == '0) ? '0 : (wb_en && wb_addr == rs) ? wb_data : regs[rs];
	assign rf_rt = (rt == '0) ? '0 : (wb_en && wb_addr == rt) ? wb_data : regs[rt];

	// Branch compare with the memory-stage result forwarded in
	assign cmp_a = hz.fwd_a_d ? xm.alu_result : rf_rs;
	assign cmp_b = hz.fwd_b_d ? xm.alu_result : rf_rt;
	assign taken = branch && ((cmp_a == cmp_b) != is_bne);

	// No redirect while held since operands may still be stale
	assign fd.redirect    = !hz.stall_d && (taken || jump);
	assign fd.redirect_pc = jump ? {fd.pc_plus4[31:28], fd.instr[25:0], 2'b00}
		: fd.pc_plus4 + {imm_ext[29:0], 2'b00};

	// Unused fields read as r0 and never match a hazard
	assign hz.rs_d     = uses_rs ? rs : '0;
	assign hz.rt_d     = uses_rt ? rt : '0;
	assign hz.branch_d = branch;

	// ------------------------------------------------------------
	// Decode/execute register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst || hz.flush_e) begin
			dx.reg_write  <= 1'b0;
			dx.mem_to_reg <= 1'b0;
			dx.mem_write  <= 1'b0;
		end else begin
			dx.reg_write  <= wr_ok;
			dx.mem_to_reg <= mem_to_reg;
			dx.mem_write  <= mem_write;
		end
	end

	always_ff @(posedge clk) begin
		dx.alu_op  <= alu_op;
		dx.alu_src <= alu_src;
		dx.reg_dst <= reg_dst;
		dx.rs      <= rs;
		dx.rt      <= rt;
		dx.rd      <= rd;
		dx.rs_val  <= rf_rs;
		dx.rt_val  <= rf_rt;
		dx.imm     <= imm_ext;
	end

	// Comparator sees zero for r0 even with forwarding in place
	a_r0_zero: assert property (@(posedge clk) disable iff (rst)
		(rs != '0 || cmp_a == '0) && (rt != '0 || cmp_b == '0));

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import mips_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	dx_if.execute      dx,
	xm_if.execute      xm,
	hazard_if.execute  hz,
	input  wire word_t wb_data
);

	word_t     src_a, src_b_reg, src_b, alu_out;
	reg_addr_t dest;

	// ------------------------------------------------------------
	// Operand forwarding
	// ------------------------------------------------------------
	always_comb begin
		case (hz.fwd_a_e)
			FWD_MEM: src_a = xm.alu_result;
			FWD_WB:  src_a = wb_data;
			default: src_a = dx.rs_val;
		endcase
	end

	// Forwarded rt is also the store data
	always_comb begin
		case (hz.fwd_b_e)
			FWD_MEM: src_b_reg = xm.alu_result;
			FWD_WB:  src_b_reg = wb_data;
			default: src_b_reg = dx.rt_val;
		endcase
	end

	assign src_b = dx.alu_src ? dx.imm : src_b_reg;

	// ALU
	always_comb begin
		case (dx.alu_op)
			ALU_SUB: alu_out = src_a - src_b;
			ALU_AND: alu_out = src_a & src_b;
			ALU_OR:  alu_out = src_a | src_b;
			// signed compare
			ALU_SLT: alu_out = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
			default: alu_out = src_a + src_b;
		endcase
	end

	// rd for R-type, rt for immediates and loads
	assign dest = dx.reg_dst ? dx.rd : dx.rt;

	// Hazard view of execute and memory
	assign hz.rs_e         = dx.rs;
	assign hz.rt_e         = dx.rt;
	assign hz.write_reg_e  = dest;
	assign hz.reg_write_e  = dx.reg_write;
	assign hz.mem_to_reg_e = dx.mem_to_reg;
	assign hz.write_reg_m  = xm.write_reg;
	assign hz.reg_write_m  = xm.reg_write;
	assign hz.mem_to_reg_m = xm.mem_to_reg;

	// ------------------------------------------------------------
	// Execute/memory register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			xm.reg_write  <= 1'b0;
			xm.mem_to_reg <= 1'b0;
			xm.mem_write  <= 1'b0;
		end else begin
			xm.reg_write  <= dx.reg_write;
			xm.mem_to_reg <= dx.mem_to_reg;
			xm.mem_write  <= dx.mem_write;
		end
	end

	always_ff @(posedge clk) begin
		xm.write_reg  <= dest;
		xm.alu_result <= alu_out;
		xm.store_data <= src_b_reg;
	end

endmodule

`default_nettype wire

/* fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import mips_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       imem_we,
	input  wire imem_addr_t imem_addr,
	input  wire word_t      imem_data,
	fd_if.fetch             fd,
	hazard_if.fetch         hz
);

	word_t imem [IMEM_DEPTH];
	word_t pc;
	word_t pc_plus4;
	word_t instr_f;

	// Program load port writes on the next edge
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_data;
	end

	// Asynchronous read indexed by the PC word address
	assign instr_f  = imem[pc[$bits(imem_addr_t)+1:2]];
	assign pc_plus4 = pc + 32'd4;

	// Load and stalls hold the PC
	always_ff @(posedge clk) begin
		if (rst)
			pc <= RESET_PC;
		else if (imem_we || hz.stall_f)
			pc <= pc;
		else if (fd.redirect)
			pc <= fd.redirect_pc;
		else
			pc <= pc_plus4;
	end

	// ------------------------------------------------------------
	// Fetch/decode register
	// ------------------------------------------------------------
	// All-zero word decodes as a bubble
	always_ff @(posedge clk) begin
		if (rst || fd.redirect || imem_we)
			fd.instr <= '0;
		else if (!hz.stall_d)
			fd.instr <= instr_f;
	end

	always_ff @(posedge clk) begin
		if (!hz.stall_d)
			fd.pc_plus4 <= pc_plus4;
	end

	// PC stays word aligned and inside the instruction memory
	a_pc_in_range: assert property (@(posedge clk) disable iff (rst)
		pc[1:0] == 2'b00 && pc[31:$bits(imem_addr_t)+2] == '0);

endmodule

`default_nettype wire

/* flist.f */
mips_pkg.sv
mips_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
mips_top.sv
tb_clock_gen.sv
tb_mips.sv

/* hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import mips_pkg::*; (
	hazard_if.hazard hz
);

	logic lw_stall, branch_stall, stall;

	// Execute forwards with the memory stage winning over writeback
	always_comb begin
		hz.fwd_a_e = FWD_REG;
		if (hz.reg_write_m && hz.write_reg_m != '0 && hz.write_reg_m == hz.rs_e)
			hz.fwd_a_e = FWD_MEM;
		else if (hz.wb_en && hz.wb_addr != '0 && hz.wb_addr == hz.rs_e)
			hz.fwd_a_e = FWD_WB;
	end

	always_comb begin
		hz.fwd_b_e = FWD_REG;
		if (hz.reg_write_m && hz.write_reg_m != '0 && hz.write_reg_m == hz.rt_e)
			hz.fwd_b_e = FWD_MEM;
		else if (hz.wb_en && hz.wb_addr != '0 && hz.wb_addr == hz.rt_e)
			hz.fwd_b_e = FWD_WB;
	end

	// Comparator forwards come from the memory stage only
	assign hz.fwd_a_d = hz.reg_write_m && hz.rs_d != '0 && hz.write_reg_m == hz.rs_d;
	assign hz.fwd_b_d = hz.reg_write_m && hz.rt_d != '0 && hz.write_reg_m == hz.rt_d;

	// Load in execute feeding decode
	// reg_write already excludes r0 as a destination
	assign lw_stall = hz.mem_to_reg_e && hz.reg_write_e
		&& (hz.write_reg_e == hz.rs_d || hz.write_reg_e == hz.rt_d);

	// Branch waits on any result in execute or a load in memory
	assign branch_stall = hz.branch_d && (
		(hz.reg_write_e && (hz.write_reg_e == hz.rs_d || hz.write_reg_e == hz.rt_d))
		|| (hz.mem_to_reg_m && hz.reg_write_m
			&& (hz.write_reg_m == hz.rs_d || hz.write_reg_m == hz.rt_d)));

	assign stall      = lw_stall || branch_stall;
	assign hz.stall_f = stall;
	assign hz.stall_d = stall;
	assign hz.flush_e = stall;

	// Worst case is two cycles for a branch on a fresh load
	a_stall_bounded: assert property (@(posedge hz.clk)
		(hz.stall_d ##1 hz.stall_d) |=> !hz.stall_d);

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import mips_pkg::*; (
	input  wire logic  clk,
	input  wire logic  rst,
	xm_if.memory       xm,
	output logic       wb_en,
	output reg_addr_t  wb_addr,
	output word_t      wb_data
);

	word_t                         dmem [DMEM_DEPTH];
	logic [$clog2(DMEM_DEPTH)-1:0] dmem_idx;
	word_t                         read_data;
	word_t                         read_data_w;
	word_t                         alu_result_w;
	logic                          mem_to_reg_w;

	// Word addressed, low two byte bits ignored
	assign dmem_idx = xm.alu_result[$clog2(DMEM_DEPTH)+1:2];

	always_ff @(posedge clk) begin
		if (xm.mem_write)
			dmem[dmem_idx] <= xm.store_data;
	end

	assign read_data = dmem[dmem_idx];

	// ------------------------------------------------------------
	// Memory/writeback register
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en        <= 1'b0;
			mem_to_reg_w <= 1'b0;
		end else begin
			wb_en        <= xm.reg_write;
			mem_to_reg_w <= xm.mem_to_reg;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr      <= xm.write_reg;
		alu_result_w <= xm.alu_result;
		read_data_w  <= read_data;
	end

	// Result mux
	assign wb_data = mem_to_reg_w ? read_data_w : alu_result_w;

endmodule

`default_nettype wire

/* mips_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Fetch/decode register outputs, redirect goes back to fetch
interface fd_if import mips_pkg::*; ();
	word_t instr;
	word_t pc_plus4;
	logic  redirect;
	word_t redirect_pc;
	modport fetch (output instr, pc_plus4, input redirect, redirect_pc);
	modport decode (input instr, pc_plus4, output redirect, redirect_pc);
endinterface

// Decode/execute register outputs
interface dx_if import mips_pkg::*; ();
	alu_op_t   alu_op;
	logic      alu_src, reg_dst, reg_write, mem_to_reg, mem_write;
	reg_addr_t rs, rt, rd;
	word_t     rs_val, rt_val, imm;
	modport decode (output alu_op, alu_src, reg_dst, reg_write, mem_to_reg, mem_write,
		rs, rt, rd, rs_val, rt_val, imm);
	modport execute (input alu_op, alu_src, reg_dst, reg_write, mem_to_reg, mem_write,
		rs, rt, rd, rs_val, rt_val, imm);
endinterface

// Execute/memory register outputs
interface xm_if import mips_pkg::*; ();
	logic      reg_write, mem_to_reg, mem_write;
	reg_addr_t write_reg;
	word_t     alu_result, store_data;
	modport execute (output reg_write, mem_to_reg, mem_write, write_reg, alu_result, store_data);
	modport memory (input reg_write, mem_to_reg, mem_write, write_reg, alu_result, store_data);
	// Decode comparator only needs the memory-stage result
	modport observe (input alu_result);
endinterface

interface hazard_if import mips_pkg::*; (input wire logic clk);
	reg_addr_t rs_d, rt_d, rs_e, rt_e, write_reg_e, write_reg_m, wb_addr;
	logic      branch_d, reg_write_e, mem_to_reg_e, reg_write_m, mem_to_reg_m, wb_en;
	fwd_sel_t  fwd_a_e, fwd_b_e;
	logic      fwd_a_d, fwd_b_d, stall_f, stall_d, flush_e;
	modport fetch (input stall_f, stall_d);
	modport decode (output rs_d, rt_d, branch_d, input fwd_a_d, fwd_b_d, stall_d, flush_e);
	modport execute (output rs_e, rt_e, write_reg_e, reg_write_e, mem_to_reg_e,
		write_reg_m, reg_write_m, mem_to_reg_m, input fwd_a_e, fwd_b_e);
	modport hazard (input clk, rs_d, rt_d, branch_d, rs_e, rt_e, write_reg_e, reg_write_e,
		mem_to_reg_e, write_reg_m, reg_write_m, mem_to_reg_m, wb_en, wb_addr,
		output fwd_a_e, fwd_b_e, fwd_a_d, fwd_b_d, stall_f, stall_d, flush_e);
endinterface

`default_nettype wire

/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

	// Datapath word, also used for instructions and addresses
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	// Instruction memory, word indexed
	localparam int IMEM_DEPTH = 256;
	typedef logic [7:0] imem_addr_t;

	// Data memory, indexed by byte address bits 9..2
	localparam int DMEM_DEPTH = 256;

	localparam word_t RESET_PC = 32'h0000_0000;

	// ------------------------------------------------------------
	// Instruction encodings
	// ------------------------------------------------------------
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_t;

	// R-type funct field
	localparam logic [5:0] FUNCT_ADD = 6'h20;
	localparam logic [5:0] FUNCT_SUB = 6'h22;
	localparam logic [5:0] FUNCT_AND = 6'h24;
	localparam logic [5:0] FUNCT_OR  = 6'h25;
	localparam logic [5:0] FUNCT_SLT = 6'h2a;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} alu_op_t;

	// Execute operand source
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10
	} fwd_sel_t;

endpackage

`default_nettype wire

/* mips_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_top import mips_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       imem_we,
	input  wire imem_addr_t imem_addr,
	input  wire word_t      imem_data,
	output logic            wb_en,
	output reg_addr_t       wb_addr,
	output word_t           wb_data
);

	// ------------------------------------------------------------
	// Stage bundles
	// ------------------------------------------------------------
	fd_if     fd0 ();
	dx_if     dx0 ();
	xm_if     xm0 ();
	hazard_if hz0 (.clk(clk));

	// Writeback port also feeds the hazard unit
	assign hz0.wb_en   = wb_en;
	assign hz0.wb_addr = wb_addr;

	fetch_stage u_fetch (
		.clk      (clk),
		.rst      (rst),
		.imem_we  (imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.fd       (fd0.fetch),
		.hz       (hz0.fetch)
	);

	decode_stage u_decode (
		.clk(clk), .rst(rst),
		.fd(fd0.decode), .dx(dx0.decode), .xm(xm0.observe), .hz(hz0.decode),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	execute_stage u_execute (
		.clk(clk), .rst(rst),
		.dx(dx0.execute), .xm(xm0.execute), .hz(hz0.execute),
		.wb_data(wb_data)
	);

	memory_stage u_memory (
		.clk(clk), .rst(rst), .xm(xm0.memory),
		.wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	hazard_unit u_hazard (.hz(hz0.hazard));

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	// 8 ns period
	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Reset held over the first five rising edges
	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* tb_mips.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips import mips_pkg::*; ();

	localparam int WB_TIMEOUT   = 30;
	localparam int RST_TIMEOUT  = 20;
	localparam int QUIET_CYCLES = 40;

	logic       clk;
	logic       rst;
	logic       imem_we;
	imem_addr_t imem_addr;
	word_t      imem_data;
	logic       wb_en;
	reg_addr_t  wb_addr;
	word_t      wb_data;

	// Program words and the writeback sequence expected from them
	word_t     prog_q [$];
	reg_addr_t exp_reg_q [$];
	word_t     exp_val_q [$];

	tb_clock_gen clk_gen0 (.clk(clk), .rst(rst));

	mips_top dut0 (
		.clk      (clk),
		.rst      (rst),
		.imem_we  (imem_we),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.wb_en    (wb_en),
		.wb_addr  (wb_addr),
		.wb_data  (wb_data)
	);

	// ------------------------------------------------------------
	// Instruction encoders
	// ------------------------------------------------------------
	function automatic word_t rtype_word(logic [5:0] funct, reg_addr_t rd, reg_addr_t rs,
		reg_addr_t rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic word_t itype_word(opcode_t op, reg_addr_t rt, reg_addr_t rs,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Target is a word index
	function automatic word_t jtype_word(logic [25:0] target);
		return {OP_J, target};
	endfunction

	task automatic abort_run(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(string name, word_t got, word_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic expect_write(reg_addr_t r, word_t v);
		exp_reg_q.push_back(r);
		exp_val_q.push_back(v);
	endtask

	// Program and results worked out by hand from the ISA rules
	task automatic fill_tables();
		prog_q.push_back(itype_word(OP_ADDI, 5'd1, 5'd0, 16'h0007));     // 0
		prog_q.push_back(itype_word(OP_ADDI, 5'd2, 5'd0, 16'hfffd));     // 1 r2 = -3
		prog_q.push_back(rtype_word(FUNCT_ADD, 5'd3, 5'd1, 5'd2));       // 2
		prog_q.push_back(rtype_word(FUNCT_SUB, 5'd4, 5'd3, 5'd1));       // 3
		prog_q.push_back(rtype_word(FUNCT_AND, 5'd5, 5'd4, 5'd1));       // 4
		prog_q.push_back(rtype_word(FUNCT_OR, 5'd6, 5'd5, 5'd2));        // 5
		prog_q.push_back(rtype_word(FUNCT_SLT, 5'd7, 5'd2, 5'd1));       // 6
		prog_q.push_back(rtype_word(FUNCT_SLT, 5'd8, 5'd1, 5'd4));       // 7
		prog_q.push_back(itype_word(OP_ORI, 5'd9, 5'd0, 16'h8001));      // 8
		prog_q.push_back(itype_word(OP_ADDI, 5'd10, 5'd0, 16'h0040));    // 9
		prog_q.push_back(itype_word(OP_SW, 5'd9, 5'd10, 16'h0004));      // 10
		prog_q.push_back(itype_word(OP_LW, 5'd11, 5'd10, 16'h0004));     // 11
		prog_q.push_back(rtype_word(FUNCT_ADD, 5'd12, 5'd11, 5'd1));     // 12 load-use
		prog_q.push_back(itype_word(OP_LW, 5'd13, 5'd10, 16'h0004));     // 13
		prog_q.push_back(itype_word(OP_BEQ, 5'd9, 5'd13, 16'h0001));     // 14 taken
		prog_q.push_back(itype_word(OP_ADDI, 5'd14, 5'd0, 16'h0111));    // 15 skipped
		prog_q.push_back(itype_word(OP_BNE, 5'd11, 5'd12, 16'h0001));    // 16 taken
		prog_q.push_back(itype_word(OP_ADDI, 5'd15, 5'd0, 16'h0222));    // 17 skipped
		prog_q.push_back(itype_word(OP_BEQ, 5'd2, 5'd1, 16'h0001));      // 18 not taken
		prog_q.push_back(itype_word(OP_ADDI, 5'd16, 5'd0, 16'h0333));    // 19
		prog_q.push_back(itype_word(OP_ADDI, 5'd17, 5'd0, 16'h0005));    // 20
		prog_q.push_back(itype_word(OP_BNE, 5'd5, 5'd17, 16'h0001));     // 21 not taken
		prog_q.push_back(itype_word(OP_ADDI, 5'd18, 5'd17, 16'h0002));   // 22
		prog_q.push_back(jtype_word(26'd25));                            // 23
		prog_q.push_back(itype_word(OP_ADDI, 5'd19, 5'd0, 16'h0444));    // 24 skipped
		prog_q.push_back(itype_word(OP_ADDI, 5'd0, 5'd0, 16'h0055));     // 25 r0 write
		prog_q.push_back(rtype_word(FUNCT_ADD, 5'd20, 5'd0, 5'd1));      // 26
		prog_q.push_back(jtype_word(26'd27));                            // 27 park here
		prog_q.push_back(32'h0000_0000);
		// Expected writebacks in program order
		expect_write(5'd1, 32'h0000_0007);
		expect_write(5'd2, 32'hffff_fffd);
		expect_write(5'd3, 32'h0000_0004);
		expect_write(5'd4, 32'hffff_fffd);
		expect_write(5'd5, 32'h0000_0005);
		expect_write(5'd6, 32'hffff_fffd);
		expect_write(5'd7, 32'h0000_0001);
		expect_write(5'd8, 32'h0000_0000);
		expect_write(5'd9, 32'h0000_8001);
		expect_write(5'd10, 32'h0000_0040);
		expect_write(5'd11, 32'h0000_8001);
		expect_write(5'd12, 32'h0000_8008);
		expect_write(5'd13, 32'h0000_8001);
		expect_write(5'd16, 32'h0000_0333);
		expect_write(5'd17, 32'h0000_0005);
		expect_write(5'd18, 32'h0000_0007);
		expect_write(5'd20, 32'h0000_0007);
	endtask

	// ------------------------------------------------------------
	// Load and wait helpers
	// ------------------------------------------------------------
	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (rst !== 1'b0 && waited < RST_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (rst !== 1'b0)
			abort_run("Reset was never released");
	endtask

	// Writes the program while wb_en must stay low
	task automatic load_program();
		int i;
		for (i = 0; i < prog_q.size(); i++) begin
			@(posedge clk);
			imem_we   <= 1'b1;
			imem_addr <= imem_addr_t'(i);
			imem_data <= prog_q[i];
			@(negedge clk);
			check_flag("wb_en", wb_en, 1'b0);
		end
		wait_reset_release();
		@(posedge clk);
		imem_we <= 1'b0;
	endtask

	task automatic wait_for_writeback();
		int waited;
		waited = 0;
		@(negedge clk);
		while (wb_en !== 1'b1 && waited < WB_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (wb_en !== 1'b1)
			abort_run("No register write arrived before the timeout");
	endtask

	initial begin
		int i;
		imem_we   = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		fill_tables();
		load_program();
		for (i = 0; i < exp_reg_q.size(); i++) begin
			wait_for_writeback();
			check_reg("wb_addr", wb_addr, exp_reg_q[i]);
			check_word("wb_data", wb_data, exp_val_q[i]);
		end
		// Core spins on its last jump and writes nothing more
		repeat (QUIET_CYCLES) begin
			@(negedge clk);
			check_flag("wb_en", wb_en, 1'b0);
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire
